/* tb/vlb_trace.txt */
# Q tor local unlocal | S slot_id | O port tor bytes | F port capacity
# E name port primary_relay secondary_relay (fires armed offers, waits for one result)
Q 3 1000 24
Q 5 0 0
S 0
O 0 3 4000
O 0 5 2500
O 0 1 777
F 0 100000
E big_cap 0 4000 2500
O 0 3 5000
O 0 5 5000
F 0 6000
E cap_limit 0 5000 1000
Q 1 200000 60000
Q 7 261000 0
S 1
O 0 1 1500
O 0 7 1000
F 0 50000
E small_buf_a 0 1500 1000
O 0 1 1000
O 0 7 1000
F 0 50000
E small_buf_b 0 644 144
Q 3 100000 100000
Q 5 250000 0
S 0
O 0 3 40000
O 0 5 10000
F 0 45000
O 1 3 30000
O 1 5 9000
F 1 60000
E both_p0 0 40000 5000
E both_p1 1 7144 22144

/* sources.f */
design/vlb_pkg.sv
design/slot_sync.sv
design/next_hop_table.sv
design/buffer_avail.sv
design/offer_arbiter.sv
design/relay_allocator.sv
design/vlb_top.sv
tb/clk_gen.sv
tb/tb_vlb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_vlb
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	! grep -q "SOME TESTS FAILED" $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/tb_vlb.sv */
`timescale 1ns/1ps

module tb_vlb;
    import vlb_pkg::*;

    localparam logic [TOR_W-1:0]  MY_TOR   = 3'd0;
    localparam logic [SIZE_W-1:0] SLOT_MAX = 32'd262144;

    logic                 i_clk;
    logic                 i_rst;
    logic                 i_slot_start;
    logic [SLOT_ID_W-1:0] i_slot_id;
    logic                 o_check_queue_req;
    logic                 i_check_queue_resp;
    logic [VEC_W-1:0]     i_local_queue;
    logic [VEC_W-1:0]     i_unlocal_queue;
    logic                 i_offer0_valid;
    logic [VEC_W-1:0]     i_offer0;
    logic [SIZE_W-1:0]    i_offer0_cap;
    logic                 i_offer1_valid;
    logic [VEC_W-1:0]     i_offer1;
    logic [SIZE_W-1:0]    i_offer1_cap;
    logic [VEC_W-1:0]     o_relay;
    logic                 o_relay_valid;
    logic                 o_relay_port;

    // trace records and counters
    string recs[$];
    int    n_rec;
    int    n_pass;
    int    n_fail;
    int    n_slot;

    // reference model state and staged offers per port
    logic [SIZE_W-1:0] m_avail   [TOR_NUM];
    logic [SIZE_W-1:0] m_local   [TOR_NUM];
    logic [SIZE_W-1:0] m_unlocal [TOR_NUM];
    logic [TOR_W-1:0]  m_hop_even;
    logic [TOR_W-1:0]  m_hop_odd;
    logic [VEC_W-1:0]  st_offer    [2];
    logic [SIZE_W-1:0] st_cap      [2];
    logic [VEC_W-1:0]  fired_offer [2];
    logic [SIZE_W-1:0] fired_cap   [2];
    logic [1:0]        armed;

    clk_gen #(.P_PERIOD(100)) clk_gen0 (.o_clk(i_clk));

    vlb_top #(.P_MY_TOR_ID(MY_TOR), .P_SLOT_MAX_BYTES(SLOT_MAX)) dut0 (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_slot_start(i_slot_start), .i_slot_id(i_slot_id),
        .o_check_queue_req(o_check_queue_req), .i_check_queue_resp(i_check_queue_resp),
        .i_local_queue(i_local_queue), .i_unlocal_queue(i_unlocal_queue),
        .i_offer0_valid(i_offer0_valid), .i_offer0(i_offer0), .i_offer0_cap(i_offer0_cap),
        .i_offer1_valid(i_offer1_valid), .i_offer1(i_offer1), .i_offer1_cap(i_offer1_cap),
        .o_relay(o_relay), .o_relay_valid(o_relay_valid), .o_relay_port(o_relay_port)
    );

    function automatic logic [SIZE_W-1:0] smaller(input logic [SIZE_W-1:0] a,
                                                  input logic [SIZE_W-1:0] b);
        return (a < b) ? a : b;
    endfunction

    task automatic report_test(input string name, input logic ok);
        if (ok) begin
            n_pass++;
            $display("PASS %s", name);
        end else begin
            n_fail++;
            $display("FAIL %s", name);
        end
    endtask

    task automatic load_trace();
        int    fd;
        int    n;
        string line;
        string kind;
        fd = $fopen("tb/vlb_trace.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                kind = "";
                n = $fgets(line, fd);
                if (n > 0) begin
                    n = $sscanf(line, "%s", kind);
                end
                // blank and comment lines are not records
                if (n > 0 && kind.getc(0) != "#") begin
                    recs.push_back(line);
                end
            end
            $fclose(fd);
        end
        n_rec = recs.size();
    endtask

    task automatic check_reset();
        logic ok;
        ok = 1'b1;
        if (o_check_queue_req !== 1'b0) begin
            $display("Mismatch reset: o_check_queue_req expected 0 actual %b", o_check_queue_req);
            ok = 1'b0;
        end
        if (o_relay_valid !== 1'b0) begin
            $display("Mismatch reset: o_relay_valid expected 0 actual %b", o_relay_valid);
            ok = 1'b0;
        end
        if (o_relay !== '0) begin
            $display("Mismatch reset: o_relay expected 0 actual %h", o_relay);
            ok = 1'b0;
        end
        report_test("reset", ok);
    endtask

    ////////////////////////////////////////////////////////////
    // slot start and queue snapshot
    ////////////////////////////////////////////////////////////

    task automatic check_slot(input int id);
        logic  ok;
        int    waited;
        int    step;
        string name;
        ok = 1'b1;
        n_slot++;
        name = $sformatf("slot_start_%0d", n_slot);
        i_slot_start = 1'b1;
        i_slot_id = SLOT_ID_W'(id);
        @(posedge i_clk);
        #1;
        i_slot_start = 1'b0;
        if (o_check_queue_req !== 1'b0) begin
            $display("Mismatch %s: o_check_queue_req expected 0 actual %b", name,
                     o_check_queue_req);
            ok = 1'b0;
        end
        @(posedge i_clk);
        #1;
        if (o_check_queue_req !== 1'b1) begin
            $display("Mismatch %s: o_check_queue_req expected 1 actual %b", name,
                     o_check_queue_req);
            ok = 1'b0;
        end
        waited = 0;
        while (o_check_queue_req === 1'b1 && waited < 40) begin
            @(posedge i_clk);
            #1;
            waited++;
        end
        if (o_check_queue_req !== 1'b0) begin
            $display("%s: queue request never dropped after the response came", name);
            ok = 1'b0;
        end
        // synchronizer drains while the free buffer loads
        repeat (6) @(posedge i_clk);
        #1;
        step = (((id + 1) % SLOT_NUM) == 0) ? 1 : 3;
        m_hop_even = TOR_W'((int'(MY_TOR) + step) % TOR_NUM);
        m_hop_odd  = TOR_W'((int'(MY_TOR) + TOR_NUM - step) % TOR_NUM);
        for (int t = 0; t < TOR_NUM; t++) begin
            m_avail[t] = SLOT_MAX - m_local[t] - m_unlocal[t];
        end
        report_test(name, ok);
    endtask

    // queue manager answers 4 cycles after it sees the request
    initial begin
        i_check_queue_resp = 1'b0;
        forever begin
            @(posedge i_clk);
            #1;
            if (o_check_queue_req === 1'b1) begin
                repeat (4) @(posedge i_clk);
                #1;
                i_check_queue_resp = 1'b1;
                while (o_check_queue_req === 1'b1) begin
                    @(posedge i_clk);
                    #1;
                end
                i_check_queue_resp = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // offers and relay results
    ////////////////////////////////////////////////////////////

    // all armed ports strobe in the same cycle
    task automatic fire_offers();
        if (armed != 2'b00) begin
            i_offer0_valid = armed[0];
            i_offer1_valid = armed[1];
            i_offer0 = st_offer[0];
            i_offer0_cap = st_cap[0];
            i_offer1 = st_offer[1];
            i_offer1_cap = st_cap[1];
            for (int p = 0; p < 2; p++) begin
                if (armed[p]) begin
                    fired_offer[p] = st_offer[p];
                    fired_cap[p] = st_cap[p];
                    st_offer[p] = '0;
                end
            end
            armed = 2'b00;
            @(posedge i_clk);
            #1;
            i_offer0_valid = 1'b0;
            i_offer1_valid = 1'b0;
        end
    endtask

    task automatic check_relay(input string name, input int port,
                               input int exp_prim, input int exp_sec);
        logic              ok;
        int                waited;
        logic [TOR_W-1:0]  ph;
        logic [TOR_W-1:0]  sh;
        logic [SIZE_W-1:0] m_prim;
        logic [SIZE_W-1:0] m_sec;
        logic [SIZE_W-1:0] want;
        logic [SIZE_W-1:0] got;
        ok = 1'b1;
        fire_offers();
        waited = 0;
        do begin
            @(posedge i_clk);
            #1;
            waited++;
        end while (o_relay_valid !== 1'b1 && waited < 20);
        if (o_relay_valid !== 1'b1) begin
            $display("%s: no relay result within 20 cycles", name);
            ok = 1'b0;
        end else begin
            // the port's own ocs hop is served first
            ph = (port == 1) ? m_hop_odd : m_hop_even;
            sh = (port == 1) ? m_hop_even : m_hop_odd;
            m_prim = smaller(smaller(fired_offer[port][ph*SIZE_W +: SIZE_W], fired_cap[port]),
                             m_avail[ph]);
            m_sec = smaller(smaller(fired_offer[port][sh*SIZE_W +: SIZE_W],
                                    fired_cap[port] - m_prim), m_avail[sh]);
            if (m_prim != exp_prim || m_sec != exp_sec) begin
                $display("%s: trace expects %0d/%0d but the reference model gives %0d/%0d",
                         name, exp_prim, exp_sec, m_prim, m_sec);
                ok = 1'b0;
            end
            if (o_relay_port !== port[0]) begin
                $display("Mismatch %s: o_relay_port expected %0d actual %b", name, port,
                         o_relay_port);
                ok = 1'b0;
            end
            for (int t = 0; t < TOR_NUM; t++) begin
                want = (TOR_W'(t) == ph) ? SIZE_W'(exp_prim) :
                       (TOR_W'(t) == sh) ? SIZE_W'(exp_sec) : '0;
                got = o_relay[t*SIZE_W +: SIZE_W];
                if (got !== want) begin
                    $display("Mismatch %s: relay[%0d] expected %0d actual %0d", name, t,
                             want, got);
                    ok = 1'b0;
                end
            end
            m_avail[ph] = m_avail[ph] - m_prim;
            m_avail[sh] = m_avail[sh] - m_sec;
        end
        report_test(name, ok);
    endtask

    task automatic run_record(input string line);
        string kind;
        string name;
        int    n;
        int    a;
        int    b;
        int    c;
        kind = "";
        name = "";
        a = 0;
        b = 0;
        c = 0;
        n = $sscanf(line, "%s %d %d %d", kind, a, b, c);
        case (kind.getc(0))
            "Q": begin
                i_local_queue[a*SIZE_W +: SIZE_W] = b;
                i_unlocal_queue[a*SIZE_W +: SIZE_W] = c;
                m_local[a] = b;
                m_unlocal[a] = c;
            end
            "S": check_slot(a);
            "O": st_offer[a][b*SIZE_W +: SIZE_W] = c;
            "F": begin
                st_cap[a] = b;
                armed[a] = 1'b1;
            end
            "E": begin
                n = $sscanf(line, "%s %s %d %d %d", kind, name, a, b, c);
                check_relay(name, a, b, c);
            end
            default: begin
                $display("trace holds a record of unknown kind: %0s", line);
                n_fail++;
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        i_rst = 1'b1;
        i_slot_start = 1'b0;
        i_slot_id = '0;
        i_local_queue = '0;
        i_unlocal_queue = '0;
        i_offer0_valid = 1'b0;
        i_offer0 = '0;
        i_offer0_cap = '0;
        i_offer1_valid = 1'b0;
        i_offer1 = '0;
        i_offer1_cap = '0;
        n_pass = 0;
        n_fail = 0;
        n_slot = 0;
        armed = 2'b00;
        m_hop_even = '0;
        m_hop_odd = '0;
        for (int t = 0; t < TOR_NUM; t++) begin
            m_avail[t] = '0;
            m_local[t] = '0;
            m_unlocal[t] = '0;
        end
        for (int p = 0; p < 2; p++) begin
            st_offer[p] = '0;
            st_cap[p] = '0;
            fired_offer[p] = '0;
            fired_cap[p] = '0;
        end
        load_trace();
        repeat (5) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
        if (n_rec == 0) begin
            $display("trace file tb/vlb_trace.txt is missing or holds no records");
            n_fail++;
        end else begin
            check_reset();
            foreach (recs[i]) begin
                run_record(recs[i]);
            end
        end
        $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // budget of 40 cycles per record
    initial begin
        wait (n_rec > 0);
        repeat (n_rec * 40 + 10) @(posedge i_clk);
        $display("timeout, the trace did not finish within %0d cycles", n_rec * 40 + 10);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* tb/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen #(
    parameter int P_PERIOD = 100
) (
    output logic o_clk
);

    // free running, starts low
    initial begin
        o_clk = 1'b0;
        forever begin
            #(P_PERIOD / 2) o_clk = ~o_clk;
        end
    end

endmodule

/* design/vlb_top.sv */
`timescale 1ns/1ps

module vlb_top #(
    parameter logic [vlb_pkg::TOR_W-1:0]  P_MY_TOR_ID      = '0,
    parameter logic [vlb_pkg::SIZE_W-1:0] P_SLOT_MAX_BYTES = 262144
) (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_slot_start,
    input  logic [vlb_pkg::SLOT_ID_W-1:0] i_slot_id,
    output logic                          o_check_queue_req,
    input  logic                          i_check_queue_resp,
    input  logic [vlb_pkg::VEC_W-1:0]     i_local_queue,
    input  logic [vlb_pkg::VEC_W-1:0]     i_unlocal_queue,
    input  logic                          i_offer0_valid,
    input  logic [vlb_pkg::VEC_W-1:0]     i_offer0,
    input  logic [vlb_pkg::SIZE_W-1:0]    i_offer0_cap,
    input  logic                          i_offer1_valid,
    input  logic [vlb_pkg::VEC_W-1:0]     i_offer1,
    input  logic [vlb_pkg::SIZE_W-1:0]    i_offer1_cap,
    output logic [vlb_pkg::VEC_W-1:0]     o_relay,
    output logic                          o_relay_valid,
    output logic                          o_relay_port
);
    import vlb_pkg::*;

    logic                 w_snap;
    logic [SLOT_ID_W-1:0] w_slot_id;
    logic [TOR_W-1:0]     w_hop_even;
    logic [TOR_W-1:0]     w_hop_odd;
    logic [VEC_W-1:0]     w_avail;
    logic                 w_grant;
    logic                 w_grant_port;
    logic [VEC_W-1:0]     w_offer;
    logic [SIZE_W-1:0]    w_cap;

    ////////////////////////////////////////////////////////////
    // slot start and queue snapshot
    ////////////////////////////////////////////////////////////

    slot_sync slot_sync0 (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_slot_start(i_slot_start), .i_slot_id(i_slot_id),
        .i_check_queue_resp(i_check_queue_resp),
        .o_check_queue_req(o_check_queue_req),
        .o_snap(w_snap), .o_slot_id(w_slot_id)
    );

    next_hop_table #(.P_MY_TOR_ID(P_MY_TOR_ID)) next_hop_table0 (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_snap(w_snap), .i_slot_id(w_slot_id),
        .o_hop_even(w_hop_even), .o_hop_odd(w_hop_odd)
    );

    // relay result feeds back to shrink the free buffer
    buffer_avail #(.P_SLOT_MAX_BYTES(P_SLOT_MAX_BYTES)) buffer_avail0 (
        .i_clk(i_clk), .i_rst(i_rst), .i_snap(w_snap),
        .i_local_queue(i_local_queue), .i_unlocal_queue(i_unlocal_queue),
        .i_relay(o_relay), .i_relay_valid(o_relay_valid),
        .o_avail(w_avail)
    );

    ////////////////////////////////////////////////////////////
    // offer service
    ////////////////////////////////////////////////////////////

    offer_arbiter offer_arbiter0 (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_offer0_valid(i_offer0_valid), .i_offer0(i_offer0), .i_offer0_cap(i_offer0_cap),
        .i_offer1_valid(i_offer1_valid), .i_offer1(i_offer1), .i_offer1_cap(i_offer1_cap),
        .i_relay_valid(o_relay_valid),
        .o_grant(w_grant), .o_grant_port(w_grant_port),
        .o_offer(w_offer), .o_cap(w_cap)
    );

    relay_allocator relay_allocator0 (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_grant(w_grant), .i_grant_port(w_grant_port),
        .i_offer(w_offer), .i_cap(w_cap), .i_avail(w_avail),
        .i_hop_even(w_hop_even), .i_hop_odd(w_hop_odd),
        .o_relay(o_relay), .o_relay_valid(o_relay_valid), .o_relay_port(o_relay_port)
    );

endmodule

/* design/relay_allocator.sv */
`timescale 1ns/1ps

module relay_allocator (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic                       i_grant,
    input  logic                       i_grant_port,
    input  logic [vlb_pkg::VEC_W-1:0]  i_offer,
    input  logic [vlb_pkg::SIZE_W-1:0] i_cap,
    input  logic [vlb_pkg::VEC_W-1:0]  i_avail,
    input  logic [vlb_pkg::TOR_W-1:0]  i_hop_even,
    input  logic [vlb_pkg::TOR_W-1:0]  i_hop_odd,
    output logic [vlb_pkg::VEC_W-1:0]  o_relay,
    output logic                       o_relay_valid,
    output logic                       o_relay_port
);
    import vlb_pkg::*;

    logic [TOR_W-1:0]        w_prim;
    logic [TOR_W-1:0]        w_sec;
    logic [SIZE_W-1:0]       w_prim_rel;
    logic [SIZE_W-1:0]       w_sec_rel;
    logic [SIZE_W-1:0]       w_cap_left;
    logic [VEC_W-1:0]        w_relay_vec;
    logic [SIZE_W+TOR_W-1:0] w_relay_sum;

    function automatic logic [SIZE_W-1:0] min3(input logic [SIZE_W-1:0] a,
                                               input logic [SIZE_W-1:0] b,
                                               input logic [SIZE_W-1:0] c);
        logic [SIZE_W-1:0] m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    // port 0 sits on the even ocs, so its own hop goes first
    assign w_prim = i_grant_port ? i_hop_odd : i_hop_even;
    assign w_sec  = i_grant_port ? i_hop_even : i_hop_odd;

    assign w_prim_rel = min3(i_offer[w_prim*SIZE_W +: SIZE_W], i_cap,
                             i_avail[w_prim*SIZE_W +: SIZE_W]);

    // secondary only gets what the primary left of the capacity
    assign w_cap_left = i_cap - w_prim_rel;
    assign w_sec_rel  = min3(i_offer[w_sec*SIZE_W +: SIZE_W], w_cap_left,
                             i_avail[w_sec*SIZE_W +: SIZE_W]);

    for (genvar t = 0; t < TOR_NUM; t++) begin : g_tor
        assign w_relay_vec[t*SIZE_W +: SIZE_W] =
            (w_prim == TOR_W'(t)) ? w_prim_rel :
            (w_sec == TOR_W'(t))  ? w_sec_rel  : '0;
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_relay       <= '0;
            o_relay_valid <= 1'b0;
            o_relay_port  <= 1'b0;
        end else begin
            o_relay_valid <= i_grant;
            if (i_grant) begin
                o_relay      <= w_relay_vec;
                o_relay_port <= i_grant_port;
            end
        end
    end

    // total over the whole result vector
    always_comb begin
        w_relay_sum = '0;
        for (int t = 0; t < TOR_NUM; t++) begin
            w_relay_sum = w_relay_sum + (SIZE_W + TOR_W)'(o_relay[t*SIZE_W +: SIZE_W]);
        end
    end

    // peer capacity of the granted offer bounds the whole result
    a_within_cap : assert property (@(posedge i_clk) disable iff (i_rst)
        o_relay_valid |-> (w_relay_sum <= (SIZE_W + TOR_W)'($past(i_cap))));

endmodule

/* design/offer_arbiter.sv */
`timescale 1ns/1ps

module offer_arbiter (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic                       i_offer0_valid,
    input  logic [vlb_pkg::VEC_W-1:0]  i_offer0,
    input  logic [vlb_pkg::SIZE_W-1:0] i_offer0_cap,
    input  logic                       i_offer1_valid,
    input  logic [vlb_pkg::VEC_W-1:0]  i_offer1,
    input  logic [vlb_pkg::SIZE_W-1:0] i_offer1_cap,
    input  logic                       i_relay_valid,
    output logic                       o_grant,
    output logic                       o_grant_port,
    output logic [vlb_pkg::VEC_W-1:0]  o_offer,
    output logic [vlb_pkg::SIZE_W-1:0] o_cap
);
    import vlb_pkg::*;

    logic [VEC_W-1:0]  r_offer0;
    logic [VEC_W-1:0]  r_offer1;
    logic [SIZE_W-1:0] r_cap0;
    logic [SIZE_W-1:0] r_cap1;
    logic [1:0]        r_pend;
    logic              r_busy;
    logic              w_issue;
    logic              w_sel;

    ////////////////////////////////////////////////////////////
    // offer capture
    ////////////////////////////////////////////////////////////

    // a newer offer simply replaces the waiting one
    always_ff @(posedge i_clk) begin
        if (i_offer0_valid) begin
            r_offer0 <= i_offer0;
            r_cap0   <= i_offer0_cap;
        end
        if (i_offer1_valid) begin
            r_offer1 <= i_offer1;
            r_cap1   <= i_offer1_cap;
        end
    end

    ////////////////////////////////////////////////////////////
    // serial grant, port 0 first
    ////////////////////////////////////////////////////////////

    assign w_issue = !r_busy && (|r_pend);
    assign w_sel   = !r_pend[0];

    // set after clear so a strobe on the granted port stays pending
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_pend <= 2'b00;
        end else begin
            if (w_issue) begin
                r_pend[w_sel] <= 1'b0;
            end
            if (i_offer0_valid) begin
                r_pend[0] <= 1'b1;
            end
            if (i_offer1_valid) begin
                r_pend[1] <= 1'b1;
            end
        end
    end

    // busy from grant until the allocator result is back
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_busy       <= 1'b0;
            o_grant      <= 1'b0;
            o_grant_port <= 1'b0;
        end else begin
            o_grant <= w_issue;
            if (w_issue) begin
                r_busy       <= 1'b1;
                o_grant_port <= w_sel;
            end else if (i_relay_valid) begin
                r_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_issue) begin
            o_offer <= w_sel ? r_offer1 : r_offer0;
            o_cap   <= w_sel ? r_cap1 : r_cap0;
        end
    end

    // each grant gets its result next cycle with no grant stacked behind it
    a_one_in_flight : assert property (@(posedge i_clk) disable iff (i_rst)
        o_grant |=> (i_relay_valid && !o_grant));

endmodule

/* design/buffer_avail.sv */
`timescale 1ns/1ps

module buffer_avail #(
    parameter logic [vlb_pkg::SIZE_W-1:0] P_SLOT_MAX_BYTES = 262144
) (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic                      i_snap,
    input  logic [vlb_pkg::VEC_W-1:0] i_local_queue,
    input  logic [vlb_pkg::VEC_W-1:0] i_unlocal_queue,
    input  logic [vlb_pkg::VEC_W-1:0] i_relay,
    input  logic                      i_relay_valid,
    output logic [vlb_pkg::VEC_W-1:0] o_avail
);
    import vlb_pkg::*;

    logic              r_snap_d;
    logic [SIZE_W-1:0] r_local   [TOR_NUM];
    logic [SIZE_W-1:0] r_unlocal [TOR_NUM];
    logic [SIZE_W-1:0] r_avail   [TOR_NUM];

    // free buffer is computed one cycle after capture
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_snap_d <= 1'b0;
        end else begin
            r_snap_d <= i_snap;
        end
    end

    for (genvar t = 0; t < TOR_NUM; t++) begin : g_tor
        // queue snapshot
        always_ff @(posedge i_clk) begin
            if (i_snap) begin
                r_local[t]   <= i_local_queue[t*SIZE_W +: SIZE_W];
                r_unlocal[t] <= i_unlocal_queue[t*SIZE_W +: SIZE_W];
            end
        end

        // fresh slot wins over a relay landing in the same cycle
        always_ff @(posedge i_clk or posedge i_rst) begin
            if (i_rst) begin
                r_avail[t] <= '0;
            end else if (r_snap_d) begin
                r_avail[t] <= P_SLOT_MAX_BYTES - r_local[t] - r_unlocal[t];
            end else if (i_relay_valid) begin
                r_avail[t] <= r_avail[t] - i_relay[t*SIZE_W +: SIZE_W];
            end
        end

        assign o_avail[t*SIZE_W +: SIZE_W] = r_avail[t];

        // allocator must never grant more than was free
        a_no_underflow : assert property (@(posedge i_clk) disable iff (i_rst)
            (i_relay_valid && !r_snap_d) |-> (i_relay[t*SIZE_W +: SIZE_W] <= r_avail[t]));
    end

endmodule

/* design/next_hop_table.sv */
`timescale 1ns/1ps

module next_hop_table #(
    parameter logic [vlb_pkg::TOR_W-1:0] P_MY_TOR_ID = '0
) (
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  logic                          i_snap,
    input  logic [vlb_pkg::SLOT_ID_W-1:0] i_slot_id,
    output logic [vlb_pkg::TOR_W-1:0]     o_hop_even,
    output logic [vlb_pkg::TOR_W-1:0]     o_hop_odd
);
    import vlb_pkg::*;

    localparam int SLOT_IDX_W = $clog2(SLOT_NUM);

    logic [TOR_W-1:0]      w_even_tbl [TOR_NUM][SLOT_NUM];
    logic [TOR_W-1:0]      w_odd_tbl  [TOR_NUM][SLOT_NUM];
    logic [SLOT_IDX_W-1:0] w_next_slot;

    // even ocs steps forward, odd ocs steps back, by 1 then 3
    for (genvar t = 0; t < TOR_NUM; t++) begin : g_tor
        for (genvar s = 0; s < SLOT_NUM; s++) begin : g_slot
            assign w_even_tbl[t][s] = TOR_W'((t + 2 * s + 1) % TOR_NUM);
            assign w_odd_tbl[t][s]  = TOR_W'((t + TOR_NUM - (2 * s + 1)) % TOR_NUM);
        end
    end

    // wraps back to slot 0 after the last one
    assign w_next_slot = SLOT_IDX_W'((int'(i_slot_id) + 1) % SLOT_NUM);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_hop_even <= '0;
            o_hop_odd  <= '0;
        end else if (i_snap) begin
            o_hop_even <= w_even_tbl[P_MY_TOR_ID][w_next_slot];
            o_hop_odd  <= w_odd_tbl[P_MY_TOR_ID][w_next_slot];
        end
    end

    // the two ocs never land on the same neighbour
    a_hops_differ : assert property (@(posedge i_clk) disable iff (i_rst)
        i_snap |=> (o_hop_even != o_hop_odd));

endmodule

/* design/slot_sync.sv */
`timescale 1ns/1ps

module slot_sync (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  logic                         i_slot_start,
    input  logic [vlb_pkg::SLOT_ID_W-1:0] i_slot_id,
    input  logic                         i_check_queue_resp,
    output logic                         o_check_queue_req,
    output logic                         o_snap,
    output logic [vlb_pkg::SLOT_ID_W-1:0] o_slot_id
);
    import vlb_pkg::*;

    logic                 r_slot_start;
    logic [SLOT_ID_W-1:0] r_slot_id;
    logic [2:0]           r_resp_sync;

    ////////////////////////////////////////////////////////////
    // slot start latch
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_slot_start <= 1'b0;
            r_slot_id    <= '0;
        end else begin
            r_slot_start <= i_slot_start;
            // id holds until the next slot pulse
            if (i_slot_start) begin
                r_slot_id <= i_slot_id;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // queue check handshake
    ////////////////////////////////////////////////////////////

    // response comes from the queue manager domain
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            r_resp_sync <= 3'b000;
        end else begin
            r_resp_sync <= {r_resp_sync[1:0], i_check_queue_resp};
        end
    end

    // request held until the synced response shows up
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_check_queue_req <= 1'b0;
        end else if (r_resp_sync[2]) begin
            o_check_queue_req <= 1'b0;
        end else if (r_slot_start) begin
            o_check_queue_req <= 1'b1;
        end
    end

    // rising edge of the synced response, queue sizes are stable here
    assign o_snap    = r_resp_sync[1] & ~r_resp_sync[2];
    assign o_slot_id = r_slot_id;

    // a snapshot only follows a request that was already out
    a_snap_after_req : assert property (@(posedge i_clk) disable iff (i_rst)
        o_snap |-> $past(o_check_queue_req, 2));

endmodule

/* design/vlb_pkg.sv */
package vlb_pkg;

    ////////////////////////////////////////////////////////////
    // network size
    ////////////////////////////////////////////////////////////

    // one queue per destination tor
    localparam int TOR_NUM = 8;
    localparam int TOR_W = 3;

    // slots in one ocs rotation
    localparam int SLOT_NUM = 2;
    localparam int SLOT_ID_W = 3;

    ////////////////////////////////////////////////////////////
    // byte counts
    ////////////////////////////////////////////////////////////

    localparam int SIZE_W = 32;

    // one byte count per tor, tor t in slice t
    localparam int VEC_W = TOR_NUM * SIZE_W;

endpackage
